// File: backend_core.f
+incdir+include
source/pipe_pkg.sv
source/pipe_control.sv
source/issue_queue.sv
source/exec_lane.sv
source/commit_stage.sv
source/backend_core.sv
tb/tb_clock_gen.sv
tb/backend_core_assertions.sv
tb/backend_core_tb.sv

// File: Makefile
SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = backend_core_tb
FILELIST  = backend_core.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/backend_core_tb.sv
`timescale 1ns/1ps

module backend_core_tb
    import pipe_pkg::*;
();

    // cycles any single wait may take
    localparam int TIMEOUT = 400;

    logic      clk;
    logic      arst_n;
    logic      reset_req;
    logic      in_valid;
    logic      in_ready;
    uop_t      in_uop;
    logic      out_valid;
    logic      out_ready;
    result_t   out_result;
    redirect_t redirect;

    // reference model, expected results in program order
    result_t          exp_q [$];
    int               seed;
    logic [TAG_W-1:0] next_tag;
    logic             pressure_on;
    logic             full_seen;
    logic             redirect_expected;
    logic             redirect_hit;
    logic [TAG_W-1:0] redirect_tag;

    tb_clock_gen u_clock_gen (
        .clk       (clk),
        .arst_n    (arst_n),
        .reset_req (reset_req)
    );

    backend_core UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_uop     (in_uop),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .redirect   (redirect)
    );

    bind backend_core backend_core_assertions u_assertions (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .redirect   (redirect)
    );

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic mismatch_error(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("ERROR t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic describe_failure(input string what);
        $display("t=%0t %s", $time, what);
        abort_run();
    endtask

    // op rules: wrapping 16-bit arithmetic, beq gives 1 when cmp is zero
    function automatic logic [DATA_W-1:0] expected_value(input uop_t u);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        a = u.payload.arith.a;
        b = u.payload.arith.b;
        case (u.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            // shift amount wraps at the data width
            OP_SHL:  return a << (b % DATA_W);
            OP_MUL:  return a * b;
            OP_BEQ:  return (u.payload.branch.cmp == '0) ? DATA_W'(1) : DATA_W'(0);
            default: return '0;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] random_data();
        return DATA_W'($random(seed));
    endfunction

    function automatic op_e random_alu_op();
        case ($unsigned($random(seed)) % 5)
            0:       return OP_ADD;
            1:       return OP_SUB;
            2:       return OP_AND;
            3:       return OP_XOR;
            default: return OP_SHL;
        endcase
    endfunction

    // offer one micro-op, optionally give up when a redirect shows
    task automatic push_uop(input uop_t u, input logic stop_on_redirect);
        int   waited;
        logic sent;
        sent     = 1'b0;
        waited   = 0;
        in_valid = 1'b1;
        in_uop   = u;
        while (!sent) begin
            @(negedge clk);
            if (stop_on_redirect && redirect.valid) begin
                redirect_hit = 1'b1;
                redirect_tag = redirect.target;
                break;
            end
            if (in_ready) begin
                sent = 1'b1;
            end else begin
                waited++;
                assert (waited < TIMEOUT)
                    else describe_failure("in_ready stayed low, micro-op never accepted");
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic issue_op(input op_e op, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b);
        uop_t u;
        u.op              = op;
        u.tag             = next_tag;
        u.payload.arith.a = a;
        u.payload.arith.b = b;
        push_uop(u, 1'b0);
        exp_q.push_back('{pad: '0, tag: u.tag, value: expected_value(u)});
        next_tag = next_tag + 1'b1;
    endtask

    task automatic issue_random(input logic with_mul);
        op_e               op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        op = with_mul ? OP_MUL : random_alu_op();
        a  = random_data();
        b  = random_data();
        issue_op(op, a, b);
    endtask

    task automatic issue_branch(input logic [DATA_W-1:0] cmp, input logic [TAG_W-1:0] target);
        uop_t u;
        u.op                    = OP_BEQ;
        u.tag                   = next_tag;
        u.payload.branch.cmp    = cmp;
        u.payload.branch.target = target;
        u.payload.branch.pad    = '0;
        push_uop(u, 1'b0);
        exp_q.push_back('{pad: '0, tag: u.tag, value: expected_value(u)});
        next_tag = next_tag + 1'b1;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            assert (waited < TIMEOUT) else describe_failure("expected results did not all arrive");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_redirect();
        int waited;
        waited = 0;
        while (!redirect_hit) begin
            @(negedge clk);
            if (redirect.valid) begin
                redirect_hit = 1'b1;
                redirect_tag = redirect.target;
            end else begin
                waited++;
                assert (waited < TIMEOUT) else describe_failure("no redirect after taken branch");
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            assert (waited < TIMEOUT) else describe_failure("reset was never released");
        end while (arst_n !== 1'b1);
        #1;
    endtask

    task automatic arith_stream();
        for (int i = 0; i < 40; i++) begin
            issue_random(1'b0);
        end
        wait_drain();
    endtask

    // two muls then one alu op, repeated
    task automatic mul_mix();
        for (int i = 0; i < 24; i++) begin
            issue_random((i % 3) != 2);
        end
        wait_drain();
    endtask

    task automatic back_pressure();
        full_seen   = 1'b0;
        pressure_on = 1'b1;
        for (int i = 0; i < 30; i++) begin
            issue_random((i % 4) == 0);
        end
        assert (full_seen) else describe_failure("in_ready never dropped under back-pressure");
        wait_drain();
        pressure_on = 1'b0;
    endtask

    task automatic taken_branch();
        logic [TAG_W-1:0] target;
        uop_t             wrong;
        int               n;
        target = 8'hC0;
        for (int i = 0; i < 4; i++) begin
            issue_random(i == 1);
        end
        redirect_expected = 1'b1;
        redirect_hit      = 1'b0;
        issue_branch('0, target);
        // wrong-path micro-ops until the redirect shows, none may commit
        n = 0;
        while (!redirect_hit && n < 12) begin
            wrong.op              = random_alu_op();
            wrong.tag             = 8'hEE;
            wrong.payload.arith.a = random_data();
            wrong.payload.arith.b = random_data();
            push_uop(wrong, 1'b1);
            n++;
        end
        wait_redirect();
        redirect_expected = 1'b0;
        assert (redirect_tag == target)
            else mismatch_error("redirect.target", 32'(target), 32'(redirect_tag));
        // restart from the target
        next_tag = target;
        for (int i = 0; i < 6; i++) begin
            issue_random(i == 3);
        end
        wait_drain();
    endtask

    task automatic not_taken_branch();
        issue_random(1'b0);
        issue_branch(random_data() | 16'h0001, 8'h40);
        for (int i = 0; i < 5; i++) begin
            issue_random(i == 2);
        end
        wait_drain();
    endtask

    task automatic reset_mid_stream();
        for (int i = 0; i < 10; i++) begin
            issue_random((i % 3) == 0);
        end
        reset_req = 1'b1;
        wait_reset_release();
        reset_req = 1'b0;
        // in-flight results are gone with the reset
        exp_q.delete();
        @(negedge clk);
        assert (!out_valid) else mismatch_error("out_valid", 32'd0, 32'(out_valid));
        @(posedge clk);
        #1;
        for (int i = 0; i < 12; i++) begin
            issue_random((i % 4) == 1);
        end
        wait_drain();
    endtask

    // random output stalls only while pressure_on
    always @(posedge clk) begin
        #1;
        if (pressure_on) begin
            out_ready = (($random(seed) & 3) == 0);
        end else begin
            out_ready = 1'b1;
        end
    end

    // any failed bound check ends the run
    always @(UUT.u_assertions.fail_count) begin
        assert (UUT.u_assertions.fail_count == 0)
            else describe_failure("a bound protocol assertion failed");
    end

    // output monitor, sampled mid-cycle where everything is settled
    always @(negedge clk) begin : monitor
        result_t expected;
        if (arst_n === 1'b1) begin
            if (!in_ready) begin
                full_seen = 1'b1;
            end
            if (redirect.valid) begin
                assert (redirect_expected)
                    else describe_failure("redirect pulse without a taken branch in flight");
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() > 0)
                    else describe_failure("result arrived when none was expected");
                expected = exp_q.pop_front();
                assert (out_result.tag == expected.tag)
                    else mismatch_error("out_result.tag", 32'(expected.tag), 32'(out_result.tag));
                assert (out_result.value == expected.value)
                    else mismatch_error("out_result.value", 32'(expected.value),
                                        32'(out_result.value));
                assert (out_result.pad == expected.pad)
                    else mismatch_error("out_result.pad", 32'(expected.pad), 32'(out_result.pad));
            end
        end
    end

    initial begin
        seed              = 30392;
        reset_req         = 1'b0;
        in_valid          = 1'b0;
        in_uop            = '0;
        out_ready         = 1'b1;
        pressure_on       = 1'b0;
        full_seen         = 1'b0;
        redirect_expected = 1'b0;
        redirect_hit      = 1'b0;
        redirect_tag      = '0;
        next_tag          = '0;
        wait_reset_release();
        arith_stream();
        mul_mix();
        back_pressure();
        taken_branch();
        not_taken_branch();
        reset_mid_stream();
        // quiet tail so a stray extra result still gets caught
        repeat (10) @(posedge clk);
        if (UUT.u_assertions.fail_count != 0) begin
            describe_failure("a bound protocol assertion failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: tb/backend_core_assertions.sv
`timescale 1ns/1ps

module backend_core_assertions
    import pipe_pkg::*;
(
    input logic      clk,
    input logic      arst_n,
    input logic      in_ready,
    input logic      out_valid,
    input logic      out_ready,
    input result_t   out_result,
    input redirect_t redirect
);

    // running count of failed checks
    int unsigned fail_count = 0;

    // a stalled output beat keeps its payload
    out_stable_on_stall: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> $stable(out_result)
    ) else begin
        fail_count++;
        $error("out_result changed while out_valid was high and out_ready low");
    end

    // redirect is a single-cycle pulse
    redirect_single_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect.valid |=> !redirect.valid
    ) else begin
        fail_count++;
        $error("redirect.valid was high for two cycles in a row");
    end

    // queue comes out of reset empty
    ready_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> in_ready
    ) else begin
        fail_count++;
        $error("in_ready was low in the first cycle after reset");
    end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n,
    input  logic reset_req
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // power-on reset for 8 cycles, then again on each reset_req rise
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        forever begin
            @(posedge reset_req);
            arst_n = 1'b0;
            repeat (8) @(posedge clk);
            #1;
            arst_n = 1'b1;
        end
    end

endmodule

// File: source/backend_core.sv
`timescale 1ns/1ps

module backend_core
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  uop_t      in_uop,
    output logic      out_valid,
    input  logic      out_ready,
    output result_t   out_result,
    output redirect_t redirect
);

    // issue to lanes
    issue_bundle_t        issue_bundle;

    // controller outputs
    logic [2:0]           hold_mask;
    logic                 issue_stall;
    logic                 flush_front;
    logic [NUM_LANES-1:0] kill_mask;

    // lane outputs
    lane_status_t         lane_status [NUM_LANES];
    result_t              lane_result [NUM_LANES];
    logic [NUM_LANES-1:0] lane_valid;

    // commit back-pressure
    logic                 commit_busy;

    issue_queue u_issue_queue (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_uop       (in_uop),
        .issue_stall  (issue_stall),
        .flush_front  (flush_front),
        .issue_bundle (issue_bundle)
    );

    pipe_control u_pipe_control (
        .lane_status (lane_status),
        .commit_busy (commit_busy),
        .hold_mask   (hold_mask),
        .issue_stall (issue_stall),
        .flush_front (flush_front),
        .kill_mask   (kill_mask),
        .redirect    (redirect)
    );

    // lane i takes bundle slot i
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        exec_lane u_exec_lane (
            .clk          (clk),
            .arst_n       (arst_n),
            .issue_uop    (issue_bundle.uop[i]),
            .issue_valid  (issue_bundle.valid[i]),
            .hold_is_ex   (hold_mask[2]),
            .hold_ex_cmt  (hold_mask[1]),
            .kill         (kill_mask[i]),
            .lane_status  (lane_status[i]),
            .result       (lane_result[i]),
            .result_valid (lane_valid[i])
        );
    end

    commit_stage u_commit_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .lane_result (lane_result),
        .lane_valid  (lane_valid),
        .commit_busy (commit_busy),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result)
    );

endmodule

// File: source/commit_stage.sv
`timescale 1ns/1ps

module commit_stage
    import pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  result_t              lane_result [NUM_LANES],
    input  logic [NUM_LANES-1:0] lane_valid,
    output logic                 commit_busy,
    output logic                 out_valid,
    input  logic                 out_ready,
    output result_t              out_result
);

    // one captured bundle, slot index equals lane index
    result_t              slot_result [NUM_LANES];
    logic [NUM_LANES-1:0] pending;
    logic [NUM_LANES-1:0] drain_onehot;
    logic                 multi;
    logic                 fire;

    // oldest undrained slot goes out first
    // invalid lanes never set pending, so they are skipped
    always_comb begin
        logic found;
        found        = 1'b0;
        drain_onehot = '0;
        out_result   = slot_result[0];
        for (int i = 0; i < NUM_LANES; i++) begin
            if (pending[i] && !found) begin
                found           = 1'b1;
                drain_onehot[i] = 1'b1;
                out_result      = slot_result[i];
            end
        end
    end

    assign out_valid = |pending;
    assign fire      = out_valid & out_ready;

    // more than one bit set
    assign multi = |(pending & (pending - 1'b1));

    // not busy means the buffer is empty or its last entry leaves now
    assign commit_busy = multi | (out_valid & ~out_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else if (!commit_busy) begin
            // next bundle replaces the drained one
            pending <= lane_valid;
        end else if (fire) begin
            pending <= pending & ~drain_onehot;
        end
    end

    // result payload, taken together with the bundle
    always_ff @(posedge clk) begin
        if (!commit_busy) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                slot_result[i] <= lane_result[i];
            end
        end
    end

endmodule

// File: source/exec_lane.sv
`timescale 1ns/1ps

module exec_lane
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  uop_t         issue_uop,
    input  logic         issue_valid,
    input  logic         hold_is_ex,
    input  logic         hold_ex_cmt,
    input  logic         kill,
    output lane_status_t lane_status,
    output result_t      result,
    output logic         result_valid
);

    logic              ex_valid;
    uop_t              ex_uop;
    logic              mul_done;
    logic              mul_busy;
    logic [DATA_W-1:0] mul_prod;
    logic [DATA_W-1:0] opnd_a;
    logic [DATA_W-1:0] opnd_b;
    logic [DATA_W-1:0] ex_value;
    logic              br_taken;

    // is_ex register, control part
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else if (!hold_is_ex) begin
            ex_valid <= issue_valid;
        end
    end

    // is_ex register, micro-op payload
    always_ff @(posedge clk) begin
        if (!hold_is_ex) begin
            ex_uop <= issue_uop;
        end
    end

    assign opnd_a = ex_uop.payload.arith.a;
    assign opnd_b = ex_uop.payload.arith.b;

    // first mul cycle raises mul_busy, second cycle has the product ready
    assign mul_busy = ex_valid & (ex_uop.op == OP_MUL) & ~mul_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mul_done <= 1'b0;
        end else if (!hold_is_ex) begin
            mul_done <= 1'b0;
        end else if (mul_busy) begin
            mul_done <= 1'b1;
        end
    end

    // low half of the product only
    always_ff @(posedge clk) begin
        if (mul_busy) begin
            mul_prod <= opnd_a * opnd_b;
        end
    end

    // payload view follows the op, beq reads the branch view
    always_comb begin
        ex_value = '0;
        br_taken = 1'b0;
        case (ex_uop.op)
            OP_ADD: ex_value = opnd_a + opnd_b;
            OP_SUB: ex_value = opnd_a - opnd_b;
            OP_AND: ex_value = opnd_a & opnd_b;
            OP_XOR: ex_value = opnd_a ^ opnd_b;
            OP_SHL: ex_value = opnd_a << opnd_b[SHAMT_W-1:0];
            OP_MUL: ex_value = mul_prod;
            OP_BEQ: begin
                br_taken = (ex_uop.payload.branch.cmp == '0);
                // 1 when taken, 0 when not
                ex_value = DATA_W'(br_taken);
            end
            default: ex_value = '0;
        endcase
    end

    assign lane_status = '{
        mul_busy: mul_busy,
        taken:    ex_valid & br_taken,
        target:   ex_uop.payload.branch.target
    };

    // ex_cmt register, a held execute stage or a kill leaves a bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else if (!hold_ex_cmt) begin
            result_valid <= ex_valid & ~hold_is_ex & ~kill;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_ex_cmt) begin
            result <= '{pad: '0, tag: ex_uop.tag, value: ex_value};
        end
    end

endmodule

// File: source/issue_queue.sv
`timescale 1ns/1ps

module issue_queue
    import pipe_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          in_valid,
    output logic          in_ready,
    input  uop_t          in_uop,
    input  logic          issue_stall,
    input  logic          flush_front,
    output issue_bundle_t issue_bundle
);

    // circular storage, head is the oldest entry
    uop_t                mem [IQ_DEPTH];
    logic [IQ_PTR_W-1:0] head;
    logic [IQ_PTR_W-1:0] tail;
    logic [IQ_CNT_W-1:0] count;
    logic                push;
    logic [IQ_CNT_W-1:0] pop_n;

    // front-end back-pressure is just the fill level
    assign in_ready = (count != IQ_CNT_W'(IQ_DEPTH));

    // a push that lands on a flush belongs to the wrong path
    assign push = in_valid & in_ready & ~flush_front;

    // up to NUM_LANES head entries, masked when nothing may issue
    // so a valid slot here means the lane takes it at this edge
    always_comb begin
        logic [IQ_PTR_W-1:0] rd_idx;
        rd_idx = head;
        for (int i = 0; i < NUM_LANES; i++) begin
            issue_bundle.valid[i] = (count > IQ_CNT_W'(i)) & ~issue_stall;
            issue_bundle.uop[i]   = mem[rd_idx];
            // pointer wraps on its own width
            rd_idx = rd_idx + 1'b1;
        end
    end

    // valid slots are contiguous from slot 0
    always_comb begin
        pop_n = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (issue_bundle.valid[i]) begin
                pop_n = pop_n + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_front) begin
            // drop every queued entry, pop is already blocked
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            head  <= head + IQ_PTR_W'(pop_n);
            count <= count + IQ_CNT_W'(push) - pop_n;
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= in_uop;
        end
    end

endmodule

// File: source/pipe_control.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module pipe_control
    import pipe_pkg::*;
(
    input  lane_status_t         lane_status [NUM_LANES],
    input  bool                  commit_busy,
    output logic [2:0]           hold_mask,
    output bool                  issue_stall,
    output bool                  flush_front,
    output logic [NUM_LANES-1:0] kill_mask,
    output redirect_t            redirect
);

    bool                  exec_stall;
    bool                  any_taken;
    logic [TAG_W-1:0]     taken_target;
    logic [NUM_LANES-1:0] younger_mask;

    // any multiplier in its first cycle stalls execute
    always_comb begin
        exec_stall = `false;
        for (int i = 0; i < NUM_LANES; i++) begin
            exec_stall = exec_stall | lane_status[i].mul_busy;
        end
    end

    // bit 2 is_ex, bit 1 ex_cmt, bit 0 unused
    // commit back-pressure wins over a multiply stall
    always_comb begin
        priority case (`true)
            commit_busy: hold_mask = 3'b110;
            exec_stall:  hold_mask = 3'b100;
            default:     hold_mask = 3'b000;
        endcase
    end

    // lane 0 is oldest, so the first taken lane found decides the redirect
    // everything above it in the bundle is younger
    always_comb begin
        any_taken    = `false;
        taken_target = '0;
        younger_mask = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (any_taken) begin
                younger_mask[i] = `true;
            end else if (lane_status[i].taken) begin
                any_taken    = `true;
                taken_target = lane_status[i].target;
            end
        end
    end

    // a branch sitting in a held execute stage waits until it moves on
    assign flush_front = any_taken & ~hold_mask[2];
    assign kill_mask   = {NUM_LANES{flush_front}} & younger_mask;

    // flush also blocks the pop so the next bundle is dropped with the queue
    assign issue_stall = commit_busy | exec_stall | flush_front;

    assign redirect = '{valid: flush_front, target: taken_target};

endmodule

// File: source/pipe_pkg.sv
package pipe_pkg;

    // pipeline shape
    localparam int NUM_LANES = 3;
    localparam int IQ_DEPTH  = 8;
    localparam int DATA_W    = 16;
    localparam int TAG_W     = 8;

    // derived widths
    localparam int IQ_PTR_W     = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W     = $clog2(IQ_DEPTH + 1);
    localparam int SHAMT_W      = $clog2(DATA_W);
    localparam int PAYLOAD_W    = 2 * DATA_W;
    localparam int BR_PAD_W     = PAYLOAD_W - DATA_W - TAG_W;
    localparam int RESULT_W     = 32;
    localparam int RESULT_PAD_W = RESULT_W - TAG_W - DATA_W;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_SHL = 3'd4,
        OP_MUL = 3'd5,
        OP_BEQ = 3'd6
    } op_e;

    // two operand view, used by every op except beq
    typedef struct packed {
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } arith_view_t;

    // beq view, taken when cmp is zero
    typedef struct packed {
        logic [DATA_W-1:0]   cmp;
        logic [TAG_W-1:0]    target;
        logic [BR_PAD_W-1:0] pad;
    } branch_view_t;

    typedef union packed {
        arith_view_t  arith;
        branch_view_t branch;
    } uop_payload_u;

    typedef struct packed {
        op_e          op;
        logic [TAG_W-1:0] tag;
        uop_payload_u payload;
    } uop_t;

    // slot 0 holds the oldest micro-op of the bundle
    typedef struct packed {
        logic [NUM_LANES-1:0] valid;
        uop_t [NUM_LANES-1:0] uop;
    } issue_bundle_t;

    typedef struct packed {
        logic             mul_busy;
        logic             taken;
        logic [TAG_W-1:0] target;
    } lane_status_t;

    typedef struct packed {
        logic [RESULT_PAD_W-1:0] pad;
        logic [TAG_W-1:0]        tag;
        logic [DATA_W-1:0]       value;
    } result_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] target;
    } redirect_t;

endpackage

// File: include/pipe_defines.svh
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// one-bit flag type for stall and flush lines
typedef logic bool;

// flag levels, also used as case selector in priority decodes
`define true  1'b1
`define false 1'b0

`endif
